// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= sim.f
TB_TOP     ?= board_link_tb
RTL_TOP    ?= board_link_top
BUILD_DIR  ?= obj_dir
RTL_SRCS   ?= $(shell grep '^design/' $(FILELIST))
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== design/board_link_top.sv ====
`timescale 1ns/1ps

module board_link_top
    import board_pkg::*;
#(
    parameter int DIV_BITS = DB_DIV_BITS
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        en_send,
    input  logic [15:0] sw,
    input  logic        ack_in,
    input  logic        req_in,
    input  logic [5:0]  data_in,
    output logic        req_out,
    output logic [5:0]  data_out,
    output logic        ack_out,
    output logic        busy,
    output logic [15:0] led
);

    logic       send_pulse;
    logic       link_en;
    logic       link_rst;
    logic       move_dir;
    logic [4:0] block_x;
    logic [2:0] block_y;
    logic [3:0] msg_type;
    logic [2:0] sel_len;

    button_conditioner #(
        .DIV_BITS (DIV_BITS)
    ) u_button (
        .clk        (clk),
        .rst        (rst),
        .button     (en_send),
        .send_pulse (send_pulse)
    );

    link_tx u_tx (
        .clk        (clk),
        .rst        (rst),
        .send_pulse (send_pulse),
        .sw         (sw),
        .ack_in     (ack_in),
        .req_out    (req_out),
        .data_out   (data_out),
        .busy       (busy)
    );

    link_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .req_in   (req_in),
        .data_in  (data_in),
        .ack_out  (ack_out),
        .link_en  (link_en),
        .link_rst (link_rst),
        .move_dir (move_dir),
        .block_x  (block_x),
        .block_y  (block_y),
        .msg_type (msg_type),
        .sel_len  (sel_len)
    );

    led_display u_led (
        .clk      (clk),
        .rst      (rst),
        .link_en  (link_en),
        .link_rst (link_rst),
        .move_dir (move_dir),
        .block_x  (block_x),
        .block_y  (block_y),
        .msg_type (msg_type),
        .sel_len  (sel_len),
        .led      (led)
    );

endmodule

// ==== design/board_pkg.sv ====
package board_pkg;

    localparam logic [15:0] LED_RESET = 16'h35ac;  // Power-on LED pattern

    localparam int DB_DIV_BITS = 18;               // Sample tick every 2^18 clocks
    localparam int DB_STABLE   = 4;                // Equal samples for a settled level

endpackage

// ==== design/button_conditioner.sv ====
`timescale 1ns/1ps

module button_conditioner
    import board_pkg::*;
#(
    parameter int DIV_BITS = DB_DIV_BITS
) (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic send_pulse
);

    logic [1:0]           btn_sync;
    logic [DIV_BITS-1:0]  div_cnt;
    logic                 tick;
    logic [DB_STABLE-1:0] samples;
    logic                 db_level;
    logic                 db_prev;

    assign tick = &div_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_sync <= '0;
            div_cnt  <= '0;
            samples  <= '0;
        end else begin
            btn_sync <= {btn_sync[0], button};      // Raw pin is asynchronous
            div_cnt  <= div_cnt + 1'b1;
            if (tick) begin
                samples <= {samples[DB_STABLE-2:0], btn_sync[1]};
            end
        end
    end

    // Level only moves when the whole window agrees
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            db_level <= 1'b0;
        end else if (&samples) begin
            db_level <= 1'b1;
        end else if (~|samples) begin
            db_level <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            db_prev    <= 1'b0;
            send_pulse <= 1'b0;
        end else begin
            db_prev    <= db_level;
            send_pulse <= db_level & ~db_prev;      // Rising edge, one clk wide
        end
    end

endmodule

// ==== design/led_display.sv ====
`timescale 1ns/1ps

module led_display
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        link_en,
    input  logic        link_rst,
    input  logic        move_dir,
    input  logic [4:0]  block_x,
    input  logic [2:0]  block_y,
    input  logic [3:0]  msg_type,
    input  logic [2:0]  sel_len,
    output logic [15:0] led
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led <= LED_RESET;
        end else if (link_rst) begin
            led <= LED_RESET;                       // Remote reset message
        end else if (link_en) begin
            led[14]    <= move_dir;                 // led[15] keeps its value
            led[13:10] <= block_x[3:0];
            led[9:7]   <= block_y;
            led[6:3]   <= msg_type;
            led[2:0]   <= sel_len;
        end
    end

endmodule

// ==== design/link_pkg.sv ====
package link_pkg;

    localparam int CHUNK_W = 6;                    // Bits per link transfer
    localparam int CHUNK_N = 4;                    // Transfers per frame

    localparam logic [3:0] MSG_RESET = 4'hF;       // Far display goes back to power-on pattern

    // Transmitter states
    localparam logic [1:0] TX_IDLE     = 2'd0;
    localparam logic [1:0] TX_REQ      = 2'd1;
    localparam logic [1:0] TX_WAIT_LOW = 2'd2;
    localparam logic [1:0] TX_NEXT     = 2'd3;

    // One 24-bit frame, either as message fields or as link chunks
    typedef union packed {
        struct packed {
            logic [1:0] pad;
            logic       move_dir;
            logic [4:0] block_x;
            logic [2:0] block_y;
            logic [3:0] msg_type;
            logic [5:0] card;                      // No source on this board, sent as zero
            logic [2:0] sel_len;
        } fields;
        logic [0:CHUNK_N-1][CHUNK_W-1:0] chunks;   // Chunk 0 is the top six bits
    } frame_t;

endpackage

// ==== design/link_rx.sv ====
`timescale 1ns/1ps

module link_rx
    import link_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               req_in,
    input  logic [CHUNK_W-1:0] data_in,
    output logic               ack_out,
    output logic               link_en,
    output logic               link_rst,
    output logic               move_dir,
    output logic [4:0]         block_x,
    output logic [2:0]         block_y,
    output logic [3:0]         msg_type,
    output logic [2:0]         sel_len
);

    logic [1:0]                 req_sync;
    logic [$clog2(CHUNK_N)-1:0] idx;
    logic                       capture;
    logic                       frame_done;
    frame_t                     frame;

    assign capture = req_sync[1] & ~ack_out;        // New chunk waiting

    always_ff @(posedge clk) begin
        if (capture) begin
            frame.chunks[idx] <= data_in;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_sync   <= '0;
            idx        <= '0;
            ack_out    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            req_sync   <= {req_sync[0], req_in};
            frame_done <= capture && (idx == CHUNK_N - 1);
            if (capture) begin
                ack_out <= 1'b1;
                idx     <= idx + 1'b1;              // Wraps to chunk 0 after the last
            end else if (!req_sync[1] && ack_out) begin
                ack_out <= 1'b0;                    // Release ack once request drops
            end
        end
    end

    assign move_dir = frame.fields.move_dir;
    assign block_x  = frame.fields.block_x;
    assign block_y  = frame.fields.block_y;
    assign msg_type = frame.fields.msg_type;
    assign sel_len  = frame.fields.sel_len;

    assign link_rst = frame_done & (frame.fields.msg_type == MSG_RESET);
    assign link_en  = frame_done & (frame.fields.msg_type != MSG_RESET);

endmodule

// ==== design/link_tx.sv ====
`timescale 1ns/1ps

module link_tx
    import link_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               send_pulse,
    input  logic [15:0]        sw,
    input  logic               ack_in,
    output logic               req_out,
    output logic [CHUNK_W-1:0] data_out,
    output logic               busy
);

    logic [1:0]                 state;
    logic [$clog2(CHUNK_N)-1:0] idx;
    logic [1:0]                 ack_sync;
    frame_t                     frame;
    frame_t                     frame_next;

    always_comb begin
        frame_next                 = '0;
        frame_next.fields.move_dir = sw[14];
        frame_next.fields.block_x  = {1'b0, sw[13:10]};
        frame_next.fields.block_y  = sw[9:7];
        frame_next.fields.msg_type = sw[6:3];
        frame_next.fields.card     = '0;
        frame_next.fields.sel_len  = sw[2:0];
    end

    assign data_out = frame.chunks[idx];            // Held while req_out is high

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_sync <= '0;
        end else begin
            ack_sync <= {ack_sync[0], ack_in};
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && send_pulse && sw[15]) begin
            frame <= frame_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= TX_IDLE;
            idx     <= '0;
            req_out <= 1'b0;
            busy    <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (send_pulse && sw[15]) begin  // Pulse dropped when disabled
                        idx   <= '0;
                        busy  <= 1'b1;
                        state <= TX_REQ;
                    end
                end
                TX_REQ: begin
                    req_out <= 1'b1;
                    if (ack_sync[1]) begin
                        req_out <= 1'b0;
                        state   <= TX_WAIT_LOW;
                    end
                end
                TX_WAIT_LOW: begin
                    if (!ack_sync[1]) begin
                        if (idx == CHUNK_N - 1) begin
                            busy  <= 1'b0;
                            state <= TX_IDLE;
                        end else begin
                            state <= TX_NEXT;
                        end
                    end
                end
                default: begin
                    idx   <= idx + 1'b1;        // New data a cycle ahead of req
                    state <= TX_REQ;
                end
            endcase
        end
    end

endmodule

// ==== sim.f ====
design/link_pkg.sv
design/board_pkg.sv
design/button_conditioner.sv
design/link_tx.sv
design/link_rx.sv
design/led_display.sv
design/board_link_top.sv
tests/board_link_tb.sv

// ==== tests/board_link_tb.sv ====
`timescale 1ns/1ps

module board_link_tb
    import link_pkg::*, board_pkg::*;
();

    localparam int CLK_PERIOD      = 10;
    localparam int DIV_BITS        = 3;
    localparam int TICK            = 1 << DIV_BITS;
    localparam int RESET_CYCLES    = 8;
    localparam int DEBOUNCE_MAX    = (DB_STABLE + 2) * TICK + 4;   // Sync plus tick phase and window
    localparam int HS_MAX          = 20;                           // One four-phase chunk
    localparam int IDLE_CYCLES     = 8 * TICK;                     // Lets the debouncer settle low
    localparam int MSG_CYCLES      = DEBOUNCE_MAX + CHUNK_N * HS_MAX + IDLE_CYCLES;
    localparam int N_RANDOM        = 20;
    localparam int N_MSGS          = N_RANDOM + 4;
    localparam int WATCHDOG_CYCLES = N_MSGS * MSG_CYCLES + 2 * RESET_CYCLES;

    logic        clk;
    logic        rst;
    logic        en_send;
    logic [15:0] sw;
    logic        req;
    logic        ack;
    logic [5:0]  data;
    logic        busy;
    logic [15:0] led;
    logic        req_q;
    logic        ack_q;
    logic [5:0]  data_q;
    logic [15:0] led_model;
    logic [31:0] rng;
    int          hs_errors;
    int          chk_errors;
    int          messages;

    // Outgoing lane looped straight back into the incoming lane
    board_link_top #(
        .DIV_BITS (DIV_BITS)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .en_send  (en_send),
        .sw       (sw),
        .ack_in   (ack),
        .req_in   (req),
        .data_in  (data),
        .req_out  (req),
        .data_out (data),
        .ack_out  (ack),
        .busy     (busy),
        .led      (led)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        req_q  <= req;
        ack_q  <= ack;
        data_q <= data;
    end

    assert property (@(posedge clk) disable iff (rst) (req && req_q) |-> (data == data_q))
    else begin
        hs_errors++;
        $display("[ERROR] data_out: changed under req_out, 0x%h -> 0x%h", data_q, data);
    end

    assert property (@(posedge clk) disable iff (rst) (ack && !ack_q) |-> req)
    else begin
        hs_errors++;
        $display("[ERROR] req_out: got 0x%h when ack_out rose, expected 0x1", req);
    end

    assert property (@(posedge clk) disable iff (rst) (req && !req_q) |-> !ack)
    else begin
        hs_errors++;
        $display("[ERROR] ack_out: got 0x%h when req_out rose, expected 0x0", ack);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic expected_led(input logic [15:0] s, input logic [15:0] prev,
                                output logic [15:0] exp);
        exp = prev;                                 // led[15] is never loaded from a frame
        if (s[6:3] == MSG_RESET) begin
            exp = LED_RESET;
        end else begin
            exp[14]    = s[14];
            exp[13:10] = s[13:10];                  // Low four bits of block_x
            exp[9:7]   = s[9:7];
            exp[6:3]   = s[6:3];
            exp[2:0]   = s[2:0];
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got == exp)
        else begin
            chk_errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic wait_busy(input logic level, input int limit, output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (n < limit && !ok) begin
            @(negedge clk);
            if (busy == level) begin
                ok = 1'b1;
            end
            n++;
        end
        if (!ok) begin
            chk_errors++;
            $display("busy did not go to %0d within %0d cycles", level, limit);
        end
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("busy", 16'(busy), 16'h0);
        end
    endtask

    task automatic send_message(input logic [15:0] value);
        logic        ok;
        logic [15:0] exp;
        @(posedge clk);
        sw      <= value;
        en_send <= 1'b1;                            // Held until the transfer starts
        wait_busy(1'b1, DEBOUNCE_MAX, ok);
        @(posedge clk);
        en_send <= 1'b0;
        sw      <= ~value;                          // Frame was latched when busy rose
        if (ok) begin
            wait_busy(1'b0, CHUNK_N * HS_MAX, ok);
        end
        expected_led(value, led_model, exp);
        check_value("led", led, exp);
        led_model = exp;
        messages++;
        repeat (IDLE_CYCLES) @(posedge clk);
    endtask

    // Press that must not start a transfer
    task automatic ignored_press(input logic [15:0] value, input int hold);
        @(posedge clk);
        sw      <= value;
        en_send <= 1'b1;
        expect_idle(hold);
        @(posedge clk);
        en_send <= 1'b0;
        expect_idle(IDLE_CYCLES);
        check_value("led", led, led_model);
    endtask

    initial begin
        logic [15:0] value;
        rst        = 1'b1;
        en_send    = 1'b0;
        sw         = '0;
        rng        = 32'd99;
        led_model  = LED_RESET;
        hs_errors  = 0;
        chk_errors = 0;
        messages   = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("led", led, LED_RESET);
        check_value("busy", 16'(busy), 16'h0);
        check_value("req_out", 16'(req), 16'h0);

        send_message(16'hEAB3);
        ignored_press(16'h9C41, TICK + 4);          // Glitch shorter than DB_STABLE ticks
        ignored_press(16'h5555, 6 * TICK);          // Transmit disabled
        send_message(16'hC47B);                     // msg_type is the reset code

        for (int i = 0; i < N_RANDOM; i++) begin
            rng       = xorshift32(rng);
            value     = rng[15:0];
            value[15] = 1'b1;
            if (value[6:3] == MSG_RESET) begin
                value[6] = 1'b0;
            end
            send_message(value);
        end

        $display("Summary: %0d messages, %0d handshake errors, %0d check errors",
                 messages, hs_errors, chk_errors);
        if (hs_errors + chk_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
